//--- filelist.f
rtl/sysmon_reg_pkg.sv
rtl/drp_pkg.sv
rtl/reg_frontend.sv
rtl/drp_sequencer.sv
rtl/sysmon_core.sv
rtl/sysmon_top.sv
verification/sysmon_checker.sv
verification/sysmon_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# exit status is nonzero on any failing check
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module sysmon_tb \
  -f filelist.f \
  -o sysmon_sim

./obj_dir/sysmon_sim

//--- verification/sysmon_tb.sv
`timescale 1ns/1ps

module sysmon_tb;

  localparam int BYTECNT_W   = 7;
  localparam int DRP_LATENCY = 4;
  localparam int MAX_CYCLES  = 3000;  // run needs well under half of this

  logic                         clk_usb = 1'b0;
  logic                         reset_i;
  logic [7:0]                   reg_address;
  logic [BYTECNT_W-1:0]         reg_bytecnt;
  logic [7:0]                   reg_datai;
  logic                         reg_read;
  logic                         reg_write;
  logic [drp_pkg::SAMPLE_W-1:0] temp_sample;
  logic [drp_pkg::SAMPLE_W-1:0] vccint_sample;
  logic [drp_pkg::SAMPLE_W-1:0] vccaux_sample;
  logic [drp_pkg::SAMPLE_W-1:0] vbram_sample;
  logic [7:0]                   reg_datao;
  logic                         sys_error;
  logic [drp_pkg::SAMPLE_W-1:0] temp_out;
  integer                       seed;           // $random state
  int                           cycle_cnt = 0;  // timeout counter
  logic [7:0]                   stat;           // last STAT readback
  logic [7:0]                   lo;             // DRP_DATA bytes
  logic [7:0]                   hi;

  sysmon_top #(
    .p_bytecnt_size (BYTECNT_W),
    .p_drp_latency  (DRP_LATENCY)
  ) UUT (
    .clk_usb, .reset_i,
    .reg_address, .reg_bytecnt, .reg_datai, .reg_read, .reg_write,
    .temp_sample, .vccint_sample, .vccaux_sample, .vbram_sample,
    .reg_datao, .sys_error, .temp_out
  );

  always #50 clk_usb = ~clk_usb;  // 100 ns period

  always @(posedge clk_usb) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal;
    end
  end

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    assert (got === expected) else begin
      $display("ERROR: %s is 0x%04h, expected 0x%04h", name, got, expected);
      $display("Test failed");
      $fatal;
    end
  endtask

  // all bus tasks start and end on a falling edge
  task automatic bus_write(input logic [7:0] addr, input int cnt, input logic [7:0] data);
    reg_address = addr;
    reg_bytecnt = cnt[BYTECNT_W-1:0];
    reg_datai   = data;
    reg_write   = 1'b1;
    @(negedge clk_usb);
    reg_write   = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, input int cnt, output logic [7:0] data);
    reg_address = addr;
    reg_bytecnt = cnt[BYTECNT_W-1:0];
    reg_read    = 1'b1;
    #10;
    data = reg_datao;  // combinational, mid low phase
    @(negedge clk_usb);
    reg_read    = 1'b0;
  endtask

  task automatic wait_idle();
    logic [7:0] st;
    bus_read(sysmon_reg_pkg::REG_STAT, 0, st);
    while (st[6]) begin  // busy bit
      bus_read(sysmon_reg_pkg::REG_STAT, 0, st);
    end
  endtask

  task automatic drp_access(input logic we, input logic [6:0] addr, input logic [15:0] data);
    if (we) begin
      bus_write(sysmon_reg_pkg::REG_DRP_DATA, 0, data[7:0]);
      bus_write(sysmon_reg_pkg::REG_DRP_DATA, 1, data[15:8]);
    end
    bus_write(sysmon_reg_pkg::REG_DRP_ADDR, 0, {we, addr});
    @(negedge clk_usb);  // request reaches the core, busy up
    wait_idle();
  endtask

  task automatic check_drp(input string name, input logic [6:0] addr,
                           input logic [15:0] expected);
    logic [7:0] b0;
    logic [7:0] b1;
    drp_access(1'b0, addr, 16'h0000);
    bus_read(sysmon_reg_pkg::REG_DRP_DATA, 0, b0);  // low byte first
    bus_read(sysmon_reg_pkg::REG_DRP_DATA, 1, b1);
    check_value(name, {b1, b0}, expected);
  endtask

  // limit with msb set stays above every sample used here
  task automatic limit_roundtrip(input string name, input logic [6:0] addr);
    logic [31:0] rnd;
    logic [15:0] lim;
    rnd = $random(seed);
    lim = {1'b1, rnd[14:0]};
    drp_access(1'b1, addr, lim);
    check_drp(name, addr, lim);
  endtask

  task automatic check_stat(input logic [7:0] expected);
    bus_read(sysmon_reg_pkg::REG_STAT, 0, stat);
    check_value("stat", 16'(stat), 16'(expected));
  endtask

  initial begin
    reset_i       = 1'b1;
    reg_address   = 8'h00;
    reg_bytecnt   = '0;
    reg_datai     = 8'h00;
    reg_read      = 1'b0;
    reg_write     = 1'b0;
    temp_sample   = '0;
    vccint_sample = '0;
    vccaux_sample = '0;
    vbram_sample  = '0;
    seed          = 69;
    repeat (16) @(posedge clk_usb);
    @(negedge clk_usb);
    reset_i = 1'b0;
    @(negedge clk_usb);

    check_stat(8'h00);  // reset state, all limits open
    check_drp("lim_temp", drp_pkg::LIM_TEMP, 16'hFFFF);
    check_drp("lim_vccint", drp_pkg::LIM_VCCINT, 16'hFFFF);
    check_drp("lim_vccaux", drp_pkg::LIM_VCCAUX, 16'hFFFF);
    check_drp("lim_ot", drp_pkg::LIM_OT, 16'hFFFF);
    check_drp("lim_vbram", drp_pkg::LIM_VBRAM, 16'hFFFF);
    check_value("sys_error", 16'(sys_error), 16'h0000);

    temp_sample   = 12'($random(seed) & 32'h7FF);  // below 0x800
    vccint_sample = 12'($random(seed) & 32'h7FF);
    vccaux_sample = 12'($random(seed) & 32'h7FF);
    vbram_sample  = 12'($random(seed) & 32'h7FF);
    repeat (2) @(negedge clk_usb);
    check_value("temp_out", 16'(temp_out), 16'(temp_sample));
    check_drp("meas_temp", drp_pkg::MEAS_TEMP, {temp_sample, 4'h0});
    check_drp("meas_vccint", drp_pkg::MEAS_VCCINT, {vccint_sample, 4'h0});
    check_drp("meas_vccaux", drp_pkg::MEAS_VCCAUX, {vccaux_sample, 4'h0});
    check_drp("meas_vbram", drp_pkg::MEAS_VBRAM, {vbram_sample, 4'h0});

    limit_roundtrip("lim_temp", drp_pkg::LIM_TEMP);
    limit_roundtrip("lim_vccint", drp_pkg::LIM_VCCINT);
    limit_roundtrip("lim_vccaux", drp_pkg::LIM_VCCAUX);
    limit_roundtrip("lim_ot", drp_pkg::LIM_OT);
    limit_roundtrip("lim_vbram", drp_pkg::LIM_VBRAM);
    drp_access(1'b1, drp_pkg::MEAS_VCCAUX, 16'hA5A5);  // read only, ignored
    check_drp("meas_vccaux", drp_pkg::MEAS_VCCAUX, {vccaux_sample, 4'h0});
    check_value("sys_error", 16'(sys_error), 16'h0000);
    check_stat(8'h00);

    vccint_sample = 12'h600;
    drp_access(1'b1, drp_pkg::LIM_VCCINT, 16'h5000);  // 0x600 > 0x500
    check_value("sys_error", 16'(sys_error), 16'h0001);
    check_stat(8'h04);
    bus_write(sysmon_reg_pkg::REG_STAT, 0, 8'h00);  // clear while still live
    @(negedge clk_usb);
    check_stat(8'h04);  // latched again
    vccint_sample = 12'h400;
    repeat (2) @(negedge clk_usb);
    check_value("sys_error", 16'(sys_error), 16'h0000);
    check_stat(8'h04);  // held after the alarm went away
    bus_write(sysmon_reg_pkg::REG_STAT, 0, 8'h00);
    check_stat(8'h00);

    temp_sample = 12'h300;
    drp_access(1'b1, drp_pkg::LIM_OT, 16'h2000);  // ot only, user limit above
    check_value("sys_error", 16'(sys_error), 16'h0001);
    check_stat(8'h01);
    drp_access(1'b1, drp_pkg::LIM_OT, 16'hFFFF);
    check_value("sys_error", 16'(sys_error), 16'h0000);
    check_stat(8'h01);
    bus_write(sysmon_reg_pkg::REG_STAT, 0, 8'h00);
    check_stat(8'h00);

    drp_access(1'b1, drp_pkg::LIM_TEMP, 16'hC3A0);
    bus_write(sysmon_reg_pkg::REG_DRP_ADDR, 0, {1'b0, drp_pkg::LIM_TEMP});
    bus_write(sysmon_reg_pkg::REG_DRP_ADDR, 0, {1'b0, drp_pkg::MEAS_VBRAM});  // dropped
    wait_idle();
    bus_read(sysmon_reg_pkg::REG_DRP_DATA, 0, lo);
    bus_read(sysmon_reg_pkg::REG_DRP_DATA, 1, hi);
    check_value("rd_data", {hi, lo}, 16'hC3A0);  // first access intact
    check_stat(8'h20);
    reg_address = sysmon_reg_pkg::REG_STAT;  // no read strobe, flag is set
    #10;
    check_value("reg_datao", 16'(reg_datao), 16'h0000);
    @(negedge clk_usb);
    bus_write(sysmon_reg_pkg::REG_STAT, 0, 8'h00);
    check_stat(8'h00);

    bus_read(8'h40, 0, stat);  // unmapped register
    check_value("reg_datao", 16'(stat), 16'h0000);
    bus_read(sysmon_reg_pkg::REG_DRP_DATA, 2, stat);  // past the data bytes
    check_value("reg_datao", 16'(stat), 16'h0000);

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- verification/sysmon_checker.sv
`timescale 1ns/1ps

module sysmon_checker #(
  parameter int p_drp_latency = 4  // en to rdy cycles, same as the core
) (
  input logic              clk_usb,
  input logic              reset_i,
  input drp_pkg::drp_req_t drp_req,  // request leaving the sequencer
  input drp_pkg::drp_rsp_t drp_rsp,  // response from the core
  input logic              busy      // sequencer busy flag
);

  logic en;   // request strobe
  logic rdy;  // response strobe

  assign en  = drp_req.en;
  assign rdy = drp_rsp.rdy;

  // strobe is a single cycle pulse
  en_one_cycle: assert property (@(posedge clk_usb) disable iff (reset_i)
    en |=> !en)
    else $error("drp_req.en high for more than one cycle");

  // a new strobe only from idle, busy comes up together with it
  en_not_busy: assert property (@(posedge clk_usb) disable iff (reset_i)
    en |-> (!$past(busy) && busy))
    else $error("drp_req.en issued while an access was outstanding");

  // rdy exactly p_drp_latency cycles after en, and never without it
  rdy_latency: assert property (@(posedge clk_usb) disable iff (reset_i)
    rdy == $past(en, p_drp_latency))
    else $error("drp_rsp.rdy not at the fixed latency after drp_req.en");

  rdy_in_access: assert property (@(posedge clk_usb) disable iff (reset_i)
    rdy |-> busy)
    else $error("drp_rsp.rdy outside an access");

  // busy released one cycle after rdy
  busy_drop: assert property (@(posedge clk_usb) disable iff (reset_i)
    rdy |=> !busy)
    else $error("busy still high in the cycle after drp_rsp.rdy");

endmodule

bind drp_sequencer sysmon_checker #(
  .p_drp_latency (4)
) u_checker (
  .clk_usb, .reset_i, .drp_req, .drp_rsp, .busy
);

//--- rtl/sysmon_top.sv
`timescale 1ns/1ps

module sysmon_top #(
  parameter int p_bytecnt_size = 7,  // bus byte count width
  parameter int p_drp_latency  = 4   // drp en to rdy cycles
) (
  input  logic                         clk_usb,
  input  logic                         reset_i,
  input  logic [7:0]                   reg_address,
  input  logic [p_bytecnt_size-1:0]    reg_bytecnt,
  input  logic [7:0]                   reg_datai,
  input  logic                         reg_read,
  input  logic                         reg_write,
  input  logic [drp_pkg::SAMPLE_W-1:0] temp_sample,
  input  logic [drp_pkg::SAMPLE_W-1:0] vccint_sample,
  input  logic [drp_pkg::SAMPLE_W-1:0] vccaux_sample,
  input  logic [drp_pkg::SAMPLE_W-1:0] vbram_sample,
  output logic [7:0]                   reg_datao,
  output logic                         sys_error,   // any live alarm
  output logic [drp_pkg::SAMPLE_W-1:0] temp_out
);

  drp_pkg::drp_req_t cmd;         // front end to sequencer
  drp_pkg::drp_req_t drp_req;     // sequencer to core
  drp_pkg::drp_rsp_t drp_rsp;     // core back to sequencer
  drp_pkg::alarm_t   alarms;      // core to front end
  logic [15:0]       rd_data;
  logic              busy;
  logic              overrun;
  logic              stat_clear;

  reg_frontend #(
    .p_bytecnt_size (p_bytecnt_size)
  ) u_frontend (
    .clk_usb, .reset_i,
    .reg_address, .reg_bytecnt, .reg_datai, .reg_read, .reg_write,
    .rd_data, .busy, .overrun, .alarms,
    .reg_datao, .cmd, .stat_clear, .sys_error
  );

  drp_sequencer u_sequencer (
    .clk_usb, .reset_i,
    .cmd, .stat_clear, .drp_rsp,
    .drp_req, .rd_data, .busy, .overrun
  );

  sysmon_core #(
    .p_drp_latency (p_drp_latency)
  ) u_core (
    .clk_usb, .reset_i, .drp_req,
    .temp_sample, .vccint_sample, .vccaux_sample, .vbram_sample,
    .drp_rsp, .alarms, .temp_out
  );

endmodule

//--- rtl/sysmon_core.sv
`timescale 1ns/1ps

module sysmon_core #(
  parameter int p_drp_latency = 4  // en to rdy cycles, no fewer than 2
) (
  input  logic                           clk_usb,
  input  logic                           reset_i,
  input  drp_pkg::drp_req_t              drp_req,        // drp request
  input  logic [drp_pkg::SAMPLE_W-1:0]   temp_sample,    // external samples
  input  logic [drp_pkg::SAMPLE_W-1:0]   vccint_sample,
  input  logic [drp_pkg::SAMPLE_W-1:0]   vccaux_sample,
  input  logic [drp_pkg::SAMPLE_W-1:0]   vbram_sample,
  output drp_pkg::drp_rsp_t              drp_rsp,        // drp response
  output drp_pkg::alarm_t                alarms,         // live alarms
  output logic [drp_pkg::SAMPLE_W-1:0]   temp_out        // registered temperature
);

  localparam int cnt_w = $clog2(p_drp_latency + 1);  // holds latency minus one
  localparam int pad_w = 16 - drp_pkg::SAMPLE_W;      // low zero bits

  logic [15:0]      meas_temp;    // left aligned measurement registers
  logic [15:0]      meas_vccint;
  logic [15:0]      meas_vccaux;
  logic [15:0]      meas_vbram;
  logic [15:0]      lim_temp;     // upper limits
  logic [15:0]      lim_vccint;
  logic [15:0]      lim_vccaux;
  logic [15:0]      lim_ot;
  logic [15:0]      lim_vbram;
  logic [cnt_w-1:0] lat_cnt;      // cycles left to rdy
  logic [6:0]       addr_q;       // address of access in flight
  logic [15:0]      rd_mux;       // addressed register

  // sample capture every cycle
  always_ff @(posedge clk_usb) begin
    meas_temp   <= {temp_sample,   {pad_w{1'b0}}};
    meas_vccint <= {vccint_sample, {pad_w{1'b0}}};
    meas_vccaux <= {vccaux_sample, {pad_w{1'b0}}};
    meas_vbram  <= {vbram_sample,  {pad_w{1'b0}}};
  end

  assign temp_out = meas_temp[15:pad_w];

  // only LIM addresses take limit writes
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      lim_temp   <= 16'hFFFF;  // alarms off
      lim_vccint <= 16'hFFFF;
      lim_vccaux <= 16'hFFFF;
      lim_ot     <= 16'hFFFF;
      lim_vbram  <= 16'hFFFF;
    end else if (drp_req.en && drp_req.we) begin
      case (drp_req.addr)
        drp_pkg::LIM_TEMP:   lim_temp   <= drp_req.din;
        drp_pkg::LIM_VCCINT: lim_vccint <= drp_req.din;
        drp_pkg::LIM_VCCAUX: lim_vccaux <= drp_req.din;
        drp_pkg::LIM_OT:     lim_ot     <= drp_req.din;
        drp_pkg::LIM_VBRAM:  lim_vbram  <= drp_req.din;
        default: ;  // measurements and holes are read only
      endcase
    end
  end

  // upper limit compare on the 12 significant bits
  always_comb begin
    alarms.ot        = meas_temp[15:pad_w]   > lim_ot[15:pad_w];
    alarms.user_temp = meas_temp[15:pad_w]   > lim_temp[15:pad_w];
    alarms.vccint    = meas_vccint[15:pad_w] > lim_vccint[15:pad_w];
    alarms.vccaux    = meas_vccaux[15:pad_w] > lim_vccaux[15:pad_w];
    alarms.vbram     = meas_vbram[15:pad_w]  > lim_vbram[15:pad_w];
  end

  always_comb begin
    case (addr_q)
      drp_pkg::MEAS_TEMP:   rd_mux = meas_temp;
      drp_pkg::MEAS_VCCINT: rd_mux = meas_vccint;
      drp_pkg::MEAS_VCCAUX: rd_mux = meas_vccaux;
      drp_pkg::MEAS_VBRAM:  rd_mux = meas_vbram;
      drp_pkg::LIM_TEMP:    rd_mux = lim_temp;
      drp_pkg::LIM_VCCINT:  rd_mux = lim_vccint;
      drp_pkg::LIM_VCCAUX:  rd_mux = lim_vccaux;
      drp_pkg::LIM_OT:      rd_mux = lim_ot;
      drp_pkg::LIM_VBRAM:   rd_mux = lim_vbram;
      default:              rd_mux = 16'h0000;  // unmapped
    endcase
  end

  always_ff @(posedge clk_usb) begin
    if (drp_req.en) addr_q <= drp_req.addr;  // latch address with the strobe
  end

  // rdy registered when the latency counter reaches one
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      lat_cnt <= '0;
      drp_rsp <= '0;
    end else begin
      if (drp_req.en) begin
        lat_cnt <= cnt_w'(p_drp_latency - 1);
      end else if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - cnt_w'(1);
      end
      drp_rsp.rdy <= (lat_cnt == cnt_w'(1));  // exactly p_drp_latency after en
      if (lat_cnt == cnt_w'(1)) begin
        drp_rsp.dout <= rd_mux;
      end
    end
  end

endmodule

//--- rtl/drp_sequencer.sv
`timescale 1ns/1ps

module drp_sequencer (
  input  logic              clk_usb,
  input  logic              reset_i,
  input  drp_pkg::drp_req_t cmd,         // command from register front end
  input  logic              stat_clear,  // host STAT write
  input  drp_pkg::drp_rsp_t drp_rsp,     // response from core
  output drp_pkg::drp_req_t drp_req,     // request to core
  output logic [15:0]       rd_data,     // last read result
  output logic              busy,        // access outstanding
  output logic              overrun      // sticky, command dropped
);

  typedef enum logic {
    IDLE,      // ready for a command
    WAIT_RDY   // access launched, waiting for rdy
  } seq_state_e;

  seq_state_e state;
  logic       accept;  // command taken this cycle
  logic       drop;    // command lost, already busy

  assign busy   = (state == WAIT_RDY);  // rises with drp_req.en
  assign accept = cmd.en && (state == IDLE);
  assign drop   = cmd.en && (state == WAIT_RDY);

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      state   <= IDLE;
      drp_req <= '0;
    end else begin
      if (accept) begin
        drp_req <= cmd;  // en comes along high
      end else begin
        drp_req.en <= 1'b0;  // payload held, we kept for capture
      end
      case (state)
        IDLE: begin
          if (accept) state <= WAIT_RDY;
        end
        WAIT_RDY: begin
          if (drp_rsp.rdy) state <= IDLE;  // busy low next cycle
        end
        default: state <= IDLE;
      endcase
    end
  end

  // capture read data, writes leave rd_data alone
  always_ff @(posedge clk_usb) begin
    if (busy && drp_rsp.rdy && !drp_req.we) begin
      rd_data <= drp_rsp.dout;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      overrun <= 1'b0;
    end else if (drop) begin
      overrun <= 1'b1;  // new drop beats a clear
    end else if (stat_clear) begin
      overrun <= 1'b0;
    end
  end

endmodule

//--- rtl/reg_frontend.sv
`timescale 1ns/1ps

module reg_frontend #(
  parameter int p_bytecnt_size = 7  // bus byte count width
) (
  input  logic                      clk_usb,
  input  logic                      reset_i,
  input  logic [7:0]                reg_address,  // register select
  input  logic [p_bytecnt_size-1:0] reg_bytecnt,  // byte index within register
  input  logic [7:0]                reg_datai,    // host write data
  input  logic                      reg_read,     // host read strobe
  input  logic                      reg_write,    // host write strobe
  input  logic [15:0]               rd_data,      // captured drp read data
  input  logic                      busy,         // drp access in flight
  input  logic                      overrun,      // sticky drop flag
  input  drp_pkg::alarm_t           alarms,       // live alarms from core
  output logic [7:0]                reg_datao,    // host read data
  output drp_pkg::drp_req_t         cmd,          // command to sequencer
  output logic                      stat_clear,   // clears overrun in sequencer
  output logic                      sys_error     // any live alarm
);

  logic                   wr_addr;    // write to DRP_ADDR
  logic                   wr_data;    // write to DRP_DATA
  logic [15:0]            din_q;      // staged drp write data
  drp_pkg::alarm_t        alarm_q;    // held alarms
  sysmon_reg_pkg::stat_t  stat_byte;  // status readback
  logic [7:0]             data_byte;  // selected rd_data byte

  assign wr_addr    = reg_write && (reg_address == sysmon_reg_pkg::REG_DRP_ADDR);
  assign wr_data    = reg_write && (reg_address == sysmon_reg_pkg::REG_DRP_DATA);
  assign stat_clear = reg_write && (reg_address == sysmon_reg_pkg::REG_STAT);

  assign sys_error = |alarms;  // live, not held

  // write data staging, byte 0 low, byte 1 high
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      din_q <= '0;
    end else if (wr_data) begin
      if (reg_bytecnt == '0) begin
        din_q[7:0] <= reg_datai;
      end else if (reg_bytecnt == p_bytecnt_size'(1)) begin
        din_q[15:8] <= reg_datai;
      end  // higher counts dropped
    end
  end

  // command pulse, one cycle after the DRP_ADDR write
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      cmd <= '0;
    end else begin
      cmd.en <= wr_addr;  // single cycle strobe
      if (wr_addr) begin
        cmd.we   <= reg_datai[sysmon_reg_pkg::DRP_WRITE_BIT];  // direction
        cmd.addr <= reg_datai[6:0];
        cmd.din  <= din_q;  // snapshot of staged data
      end
    end
  end

  // alarms may be transient, hold until host clears
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      alarm_q <= '0;
    end else if (stat_clear) begin
      alarm_q <= '0;  // live ones come back next cycle
    end else begin
      alarm_q <= drp_pkg::alarm_t'(alarm_q | alarms);
    end
  end

  always_comb begin
    stat_byte.zero      = 1'b0;
    stat_byte.busy      = busy;     // live
    stat_byte.overrun   = overrun;  // sticky in sequencer
    stat_byte.vbram     = alarm_q.vbram;
    stat_byte.vccaux    = alarm_q.vccaux;
    stat_byte.vccint    = alarm_q.vccint;
    stat_byte.user_temp = alarm_q.user_temp;
    stat_byte.ot        = alarm_q.ot;
  end

  always_comb begin
    if (reg_bytecnt == '0) begin
      data_byte = rd_data[7:0];
    end else if (reg_bytecnt == p_bytecnt_size'(1)) begin
      data_byte = rd_data[15:8];
    end else begin
      data_byte = 8'h00;  // past end of register
    end
  end

  // readback mux, zero when not reading
  always_comb begin
    reg_datao = 8'h00;
    if (reg_read) begin
      case (reg_address)
        sysmon_reg_pkg::REG_DRP_ADDR: reg_datao = {cmd.we, cmd.addr};  // last command
        sysmon_reg_pkg::REG_DRP_DATA: reg_datao = data_byte;
        sysmon_reg_pkg::REG_STAT:     reg_datao = stat_byte;
        default:                      reg_datao = 8'h00;  // unmapped
      endcase
    end
  end

endmodule

//--- rtl/drp_pkg.sv
package drp_pkg;

  // sample width from the sensor front
  localparam int SAMPLE_W = 12;  // stored left aligned in 16 bits

  // drp address map of the sensor monitor
  typedef enum logic [6:0] {
    MEAS_TEMP   = 7'h00,  // temperature measurement
    MEAS_VCCINT = 7'h01,  // vccint measurement
    MEAS_VCCAUX = 7'h02,  // vccaux measurement
    MEAS_VBRAM  = 7'h06,  // vbram measurement
    LIM_TEMP    = 7'h50,  // user temperature upper limit
    LIM_VCCINT  = 7'h51,  // vccint upper limit
    LIM_VCCAUX  = 7'h52,  // vccaux upper limit
    LIM_OT      = 7'h53,  // over-temperature upper limit
    LIM_VBRAM   = 7'h58   // vbram upper limit
  } drp_addr_e;

  // drp request, en is a single cycle strobe
  typedef struct packed {
    logic        en;    // access strobe
    logic        we;    // 1 = write, 0 = read
    logic [6:0]  addr;  // raw address, may be unmapped
    logic [15:0] din;   // write data
  } drp_req_t;

  // drp response, rdy pulses once per access
  typedef struct packed {
    logic        rdy;   // access done
    logic [15:0] dout;  // read data, valid with rdy
  } drp_rsp_t;

  // live alarms, same bit order as the status byte
  typedef struct packed {
    logic vbram;      // bit 4
    logic vccaux;     // bit 3
    logic vccint;     // bit 2
    logic user_temp;  // bit 1
    logic ot;         // bit 0
  } alarm_t;

endpackage

//--- rtl/sysmon_reg_pkg.sv
package sysmon_reg_pkg;

  // host side register map, byte wide registers on the usb register bus
  typedef enum logic [7:0] {
    REG_DRP_ADDR = 8'h30,  // launch drp access, bit 7 selects write
    REG_DRP_DATA = 8'h31,  // staged write data / captured read data
    REG_STAT     = 8'h32   // held alarms, overrun, busy
  } reg_addr_e;

  // direction flag inside a DRP_ADDR write
  localparam int DRP_WRITE_BIT = 7;  // set = drp write, clear = drp read

  // status byte as seen by the host, msb first
  typedef struct packed {
    logic zero;       // bit 7, always reads 0
    logic busy;       // bit 6, drp access in flight
    logic overrun;    // bit 5, sticky, command dropped while busy
    logic vbram;      // bit 4, held vbram alarm
    logic vccaux;     // bit 3, held vccaux alarm
    logic vccint;     // bit 2, held vccint alarm
    logic user_temp;  // bit 1, held user temperature alarm
    logic ot;         // bit 0, held over-temperature alarm
  } stat_t;

  // host write of any value to REG_STAT clears the held bits
  // live alarms re-latch on the following cycle

endpackage
